// File: verilog.f
hw/credit_pkg.sv
hw/fifo_if.sv
hw/addr_issue.sv
hw/index_fifo.sv
hw/ram1_engine.sv
hw/out_fifo.sv
hw/credit_top.sv
test/credit_properties.sv
test/credit_tb.sv

// File: Bender.yml
package:
  name: credit_lookup

sources:
  - hw/credit_pkg.sv
  - hw/fifo_if.sv
  - hw/addr_issue.sv
  - hw/index_fifo.sv
  - hw/ram1_engine.sv
  - hw/out_fifo.sv
  - hw/credit_top.sv
  - target: test
    files:
      - test/credit_properties.sv
      - test/credit_tb.sv

// File: test/credit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module credit_tb import credit_pkg::*; ();

  logic               clk;
  logic               rst_n;
  logic [addr_w-1:0]  addr;
  logic               addr_valid;
  logic               addr_ready;
  logic [addr_w-1:0]  ram0_addr;
  logic               ram0_read;
  logic [data_w-1:0]  ram0_data;
  logic               ram0_valid;
  logic [addr_w-1:0]  ram1_addr;
  logic               ram1_read;
  logic [data_w-1:0]  ram1_data;
  logic               ram1_valid;
  logic               fifo_rd_en;
  logic [data_w-1:0]  fifo_dout;
  logic               fifo_full;
  logic               fifo_empty;
  logic [count_w-1:0] fifo_data_count;
  logic               fifo_overflow;
  logic               fifo_underflow;
  logic               index_overflow;

  logic [31:0]       rng;                       // xorshift state
  logic [data_w-1:0] ram0_tab [1 << addr_w];
  logic [data_w-1:0] ram1_tab [1 << addr_w];
  logic [data_w-1:0] expect_q [$];              // words still owed to the reader
  int errors;
  int tests_run;
  int tests_failed;
  int accepted;                                 // address handshakes seen
  int popped;                                   // accepted reads seen

  credit_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng = x;
    return x;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s at %0t", what, $time);
    errors++;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;                                         // drive just after the edge
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) next_cycle();
    rst_n = 1'b1;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!addr_ready && n < 100) begin
      next_cycle();
      n++;
    end
    if (!addr_ready)
      report_timeout("addr_ready");
  endtask

  // read until the model owes nothing
  task automatic drain_fifo();
    int n;
    n = 0;
    while (expect_q.size() != 0 && n < 300) begin
      fifo_rd_en = !fifo_empty;
      next_cycle();
      n++;
    end
    fifo_rd_en = 1'b0;
    if (expect_q.size() != 0)
      report_timeout("the output fifo to drain");
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // both tables answer a read pulse one cycle later
  initial begin
    logic              r0;
    logic              r1;
    logic [addr_w-1:0] a0;
    logic [addr_w-1:0] a1;
    forever begin
      @(negedge clk);                           // read strobes settled mid-cycle
      r0 = ram0_read;
      a0 = ram0_addr;
      r1 = ram1_read;
      a1 = ram1_addr;
      next_cycle();
      ram0_valid = r0;
      ram0_data  = ram0_tab[a0];
      ram1_valid = r1;
      ram1_data  = ram1_tab[a1];
    end
  end

  // reference model fed and checked mid-cycle
  initial begin
    logic [data_w-1:0] exp_word;
    forever begin
      @(negedge clk);
      if (rst_n && addr_valid && addr_ready) begin
        expect_q.push_back(ram1_tab[ram0_tab[addr][addr_w-1:0]]);   // two-level lookup
        accepted++;
      end
      if (rst_n && fifo_rd_en && !fifo_empty) begin
        if (expect_q.size() == 0) begin
          $display("read returned a word that was never requested at %0t", $time);
          errors++;
        end else begin
          exp_word = expect_q.pop_front();
          check_eq("fifo_dout", fifo_dout, exp_word);
        end
        popped++;
      end
    end
  end

  initial begin
    int          errs;
    int          n;
    int          acc0;
    int          pop0;
    logic [31:0] r;
    rst_n      = 1'b0;
    addr       = '0;
    addr_valid = 1'b0;
    ram0_data  = '0;
    ram0_valid = 1'b0;
    ram1_data  = '0;
    ram1_valid = 1'b0;
    fifo_rd_en = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    accepted = 0;
    popped = 0;
    rng = 32'd30;
    for (int i = 0; i < (1 << addr_w); i++) begin
      r = next_rand();
      ram0_tab[i] = r[data_w-1:0];
      ram1_tab[i] = r[31:32-data_w];
    end
    apply_reset();

    errs = errors;
    check_eq("addr_ready", addr_ready, 0);
    check_eq("fifo_overflow", fifo_overflow, 0);
    check_eq("fifo_underflow", fifo_underflow, 0);
    check_eq("index_overflow", index_overflow, 0);
    check_eq("fifo_empty", fifo_empty, 1);
    check_eq("fifo_data_count", fifo_data_count, 0);
    finish_test("reset", errs);

    errs = errors;
    wait_ready();
    r = next_rand();
    addr       = r[addr_w-1:0];
    addr_valid = 1'b1;
    next_cycle();                               // handshake at this edge
    addr_valid = 1'b0;
    n = 0;
    while (fifo_empty && n < 20) begin
      next_cycle();
      n++;
    end
    check_eq("latency_edges", n, 4);
    pop0 = popped;
    drain_fifo();                               // model checks dout
    check_eq("words_read", popped - pop0, 1);
    wait_ready();
    finish_test("latency", errs);

    errs = errors;
    acc0 = accepted;
    pop0 = popped;
    n = 0;
    while (popped - pop0 < 300 && n < 5000) begin
      r = next_rand();
      addr       = r[addr_w-1:0];
      addr_valid = (accepted - acc0 < 300) && r[8];
      fifo_rd_en = r[9] && !fifo_empty;         // no reads while empty here
      next_cycle();
      n++;
    end
    addr_valid = 1'b0;
    fifo_rd_en = 1'b0;
    if (popped - pop0 < 300)
      report_timeout("300 words to stream through");
    check_eq("stream_accepted", accepted - acc0, 300);
    check_eq("words_left", expect_q.size(), 0);
    wait_ready();
    finish_test("random stream", errs);

    errs = errors;
    acc0 = accepted;
    n = 0;
    while (addr_ready && n < 100) begin
      r = next_rand();
      addr       = r[addr_w-1:0];
      addr_valid = 1'b1;
      next_cycle();
      n++;
    end
    addr_valid = 1'b0;
    check_eq("credit_accepted", accepted - acc0, out_depth);
    n = 0;
    while (!fifo_full && n < 50) begin
      next_cycle();
      n++;
    end
    if (!fifo_full)
      report_timeout("fifo_full");
    check_eq("fifo_data_count", fifo_data_count, out_depth);
    check_eq("addr_ready", addr_ready, 0);
    check_eq("fifo_overflow", fifo_overflow, 0);
    check_eq("index_overflow", index_overflow, 0);
    drain_fifo();
    wait_ready();
    finish_test("credit limit", errs);

    errs = errors;
    check_eq("fifo_empty", fifo_empty, 1);
    fifo_rd_en = 1'b1;                          // read with nothing stored
    next_cycle();
    fifo_rd_en = 1'b0;
    check_eq("fifo_underflow", fifo_underflow, 1);
    repeat (3) begin
      next_cycle();
      check_eq("fifo_underflow", fifo_underflow, 1);   // sticky
    end
    apply_reset();
    check_eq("fifo_underflow", fifo_underflow, 0);
    finish_test("underflow", errs);

    if (dut_i.props_i.fail_count != 0) begin
      $display("%0d bound assertions failed", dut_i.props_i.fail_count);
      errors += dut_i.props_i.fail_count;
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/credit_properties.sv
`timescale 1ns/1ps
`default_nettype none

// safety checks on the credit loop bound into credit_top
module credit_properties import credit_pkg::*; (
  input wire               clk,
  input wire               rst_n,
  input wire               addr_valid,
  input wire               addr_ready,
  input wire               ram0_read,
  input wire               ram0_valid,
  input wire               ram1_valid,
  input wire [count_w-1:0] fifo_data_count,
  input wire               fifo_overflow,
  input wire               index_overflow
);

  int in_flight;    // accepted addresses not yet written into the output fifo
  int fail_count;   // failed assertions so far

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      in_flight <= 0;
    else
      in_flight <= in_flight + int'(addr_valid && addr_ready) - int'(ram1_valid);
  end

  // stored plus in flight never passes the depth, so the count cannot either
  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    (in_flight + int'(fifo_data_count)) <= out_depth)
    else begin
      $error("stored plus in-flight words above the output fifo depth");
      fail_count++;
    end

  // stored plus in flight at the limit means no more addresses
  a_credit_stop: assert property (@(posedge clk) disable iff (!rst_n)
    (in_flight + int'(fifo_data_count) >= out_depth) |-> !addr_ready)
    else begin
      $error("addr_ready high with credit exhausted");
      fail_count++;
    end

  a_ram0_answer: assert property (@(posedge clk) disable iff (!rst_n)
    ram0_read |=> ram0_valid)
    else begin
      $error("ram0 read not answered one cycle later");
      fail_count++;
    end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    !fifo_overflow && !index_overflow)
    else begin
      $error("fifo overflow flag set");
      fail_count++;
    end

endmodule

bind credit_top credit_properties props_i (.*);

`default_nettype wire

// File: hw/credit_top.sv
`timescale 1ns/1ps
`default_nettype none

// two-stage dependent lookup with both tables outside
// addr -> ram0 -> index fifo -> ram1 -> output fifo -> user
module credit_top import credit_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,

  input  wire  [addr_w-1:0]  addr,
  input  wire                addr_valid,
  output logic               addr_ready,

  output logic [addr_w-1:0]  ram0_addr,
  output logic               ram0_read,
  input  wire  [data_w-1:0]  ram0_data,
  input  wire                ram0_valid,

  output logic [addr_w-1:0]  ram1_addr,
  output logic               ram1_read,
  input  wire  [data_w-1:0]  ram1_data,
  input  wire                ram1_valid,

  input  wire                fifo_rd_en,
  output logic [data_w-1:0]  fifo_dout,
  output logic               fifo_full,
  output logic               fifo_empty,
  output logic [count_w-1:0] fifo_data_count,
  output logic               fifo_overflow,
  output logic               fifo_underflow,
  output logic               index_overflow
);

  logic fifo_pop;   // accepted user read returns one credit

  fifo_if idx_q ();   // addr_issue -> index_fifo -> ram1_engine
  fifo_if out_q ();   // ram1_engine -> out_fifo

  addr_issue u_addr_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr       (addr),
    .addr_valid (addr_valid),
    .addr_ready (addr_ready),
    .ram0_addr  (ram0_addr),
    .ram0_read  (ram0_read),
    .ram0_data  (ram0_data),
    .ram0_valid (ram0_valid),
    .pop        (fifo_pop),
    .idx        (idx_q.writer)
  );

  index_fifo u_index_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .q        (idx_q.fifo),
    .overflow (index_overflow)
  );

  ram1_engine u_ram1_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .idx        (idx_q.reader),
    .ram1_addr  (ram1_addr),
    .ram1_read  (ram1_read),
    .ram1_data  (ram1_data),
    .ram1_valid (ram1_valid),
    .outq       (out_q.writer)
  );

  out_fifo u_out_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .q          (out_q.fifo),
    .rd_en      (fifo_rd_en),
    .dout       (fifo_dout),
    .empty      (fifo_empty),
    .full       (fifo_full),
    .data_count (fifo_data_count),
    .pop        (fifo_pop),
    .overflow   (fifo_overflow),
    .underflow  (fifo_underflow)
  );

endmodule

`default_nettype wire

// File: hw/out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// user-facing output fifo
// show-ahead head on dout, occupancy count, pop pulse for the credit
// counter and sticky misuse flags
module out_fifo import credit_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  fifo_if.fifo               q,

  input  wire                rd_en,        // external read strobe
  output logic [data_w-1:0]  dout,         // head word while empty is low
  output logic               empty,
  output logic               full,
  output logic [count_w-1:0] data_count,
  output logic               pop,          // one cycle per accepted read
  output logic               overflow,     // write while full, sticky
  output logic               underflow     // read while empty, sticky
);

  logic [data_w-1:0] mem [out_depth];

  // pointers wrap naturally at out_depth, count tells full from empty
  logic [$clog2(out_depth)-1:0] wr_ptr;
  logic [$clog2(out_depth)-1:0] rd_ptr;
  logic [count_w-1:0]           count;

  logic push;
  logic pull;

  assign empty = (count == '0);
  assign full  = (count == count_w'(out_depth));

  assign push = q.wr_en & ~full;
  assign pull = rd_en & ~empty;

  assign dout       = mem[rd_ptr];
  assign data_count = count;

  // writer side sees the same status
  assign q.full    = full;
  assign q.empty   = empty;
  assign q.rd_data = dout;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pop       <= 1'b0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pull)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // idle, or push and pull together
      endcase
      pop <= pull;                     // credit returns a cycle after the read
      if (q.wr_en && full)
        overflow <= 1'b1;
      if (rd_en && empty)
        underflow <= 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= q.wr_data;
  end

endmodule

`default_nettype wire

// File: hw/ram1_engine.sv
`timescale 1ns/1ps
`default_nettype none

// second lookup stage
// drains the index fifo one word per cycle, turns each word into a
// ram1 read and forwards the ram1 answer to the output fifo
module ram1_engine import credit_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,

  fifo_if.reader            idx,

  output logic [addr_w-1:0] ram1_addr,
  output logic              ram1_read,    // registered, one cycle after the pop
  input  wire  [data_w-1:0] ram1_data,
  input  wire               ram1_valid,   // one cycle after ram1_read

  fifo_if.writer            outq
);

  logic take;   // pop the index fifo this cycle

  // nothing downstream stalls, so take whenever something is there
  assign take      = ~idx.empty;
  assign idx.rd_en = take;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      ram1_read <= 1'b0;
    else
      ram1_read <= take;
  end

  // low bits of the ram0 word address ram1
  always_ff @(posedge clk) begin
    if (take)
      ram1_addr <= idx.rd_data[addr_w-1:0];
  end

  // credit keeps outq from filling, push unconditionally
  assign outq.wr_en   = ram1_valid;
  assign outq.wr_data = ram1_data;

endmodule

`default_nettype wire

// File: hw/index_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// small register fifo holding ram0 words until ram1_engine takes them
module index_fifo import credit_pkg::*; (
  input  wire    clk,
  input  wire    rst_n,
  fifo_if.fifo   q,
  output logic   overflow        // push seen while full, held until reset
);

  logic [data_w-1:0] mem [index_depth];

  // extra msb on each pointer tells full from empty
  logic [$clog2(index_depth):0] wr_ptr;
  logic [$clog2(index_depth):0] rd_ptr;

  logic push;
  logic pull;

  assign q.empty = (wr_ptr == rd_ptr);
  assign q.full  = (wr_ptr[$clog2(index_depth)] != rd_ptr[$clog2(index_depth)]) &&
                   (wr_ptr[$clog2(index_depth)-1:0] == rd_ptr[$clog2(index_depth)-1:0]);

  assign push = q.wr_en & ~q.full;   // full push dropped
  assign pull = q.rd_en & ~q.empty;  // empty pop ignored

  // show-ahead head word
  assign q.rd_data = mem[rd_ptr[$clog2(index_depth)-1:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pull)
        rd_ptr <= rd_ptr + 1'b1;
      if (q.wr_en && q.full)
        overflow <= 1'b1;   // sticky
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr[$clog2(index_depth)-1:0]] <= q.wr_data;
  end

endmodule

`default_nettype wire

// File: hw/addr_issue.sv
`timescale 1ns/1ps
`default_nettype none

// front of the pipeline
// takes addresses while credit lasts, starts the ram0 read and
// pushes whatever ram0 returns into the index fifo
module addr_issue import credit_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,

  input  wire [addr_w-1:0] addr,         // ram0 address from the stream
  input  wire              addr_valid,
  output logic             addr_ready,

  output logic [addr_w-1:0] ram0_addr,
  output logic              ram0_read,   // one pulse per accepted address
  input  wire  [data_w-1:0] ram0_data,
  input  wire               ram0_valid,  // one cycle after ram0_read

  input  wire              pop,          // output fifo handed a word to the user

  fifo_if.writer           idx
);

  logic [count_w-1:0] credit;       // accepted and not yet popped
  logic [count_w-1:0] credit_nxt;
  logic               ready_q;      // registered so it is low out of reset
  logic               xfer;         // address handshake this cycle

  assign xfer       = addr_valid & ready_q;
  assign addr_ready = ready_q;

  // ram0 read goes out in the same cycle as the handshake
  assign ram0_addr = addr;
  assign ram0_read = xfer;

  // an accept and a pop in one cycle cancel out
  always_comb begin
    case ({xfer, pop})
      2'b10:   credit_nxt = credit + 1'b1;
      2'b01:   credit_nxt = credit - 1'b1;
      default: credit_nxt = credit;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit  <= '0;
      ready_q <= 1'b0;
    end else begin
      credit  <= credit_nxt;
      // ready for next cycle follows the updated count, so at most
      // out_depth words are ever outstanding
      ready_q <= (credit_nxt < count_w'(out_depth));
    end
  end

  // ram0 has no back-pressure, every returning word is pushed
  assign idx.wr_en   = ram0_valid;
  assign idx.wr_data = ram0_data;

endmodule

`default_nettype wire

// File: hw/fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

// write and read sides of one fifo
// no clock inside, every side samples its own clk
interface fifo_if import credit_pkg::*; ();

  logic [data_w-1:0] wr_data;   // word to push
  logic              wr_en;     // push strobe
  logic              full;      // no room left

  logic              rd_en;     // pop strobe
  logic [data_w-1:0] rd_data;   // head word, valid while empty is low
  logic              empty;     // nothing stored

  // producer side
  modport writer (
    output wr_data,
    output wr_en,
    input  full
  );

  // consumer side
  modport reader (
    output rd_en,
    input  rd_data,
    input  empty
  );

  // the storage itself
  modport fifo (
    input  wr_data,
    input  wr_en,
    input  rd_en,
    output full,
    output rd_data,
    output empty
  );

endinterface

`default_nettype wire

// File: hw/credit_pkg.sv
`default_nettype none

// widths and depths shared by the lookup pipeline
package credit_pkg;

  // ram0 address, and the ram1 address taken from the low bits of a ram0 word
  localparam int addr_w = 8;

  // ram0 word, ram1 word and output fifo word
  localparam int data_w = 16;

  // index fifo between the two lookups
  // occupancy stays at one or below while ram1_engine drains every cycle
  localparam int index_depth = 4;

  // output fifo depth, doubles as the credit limit
  localparam int out_depth = 16;

  // must hold 0..out_depth inclusive
  localparam int count_w = 5;

endpackage

`default_nettype wire
